// File: Bender.yml
package:
  name: muldiv

sources:
  - files:
      - source/muldiv_pkg.sv
      - source/muldiv_issue.sv
      - source/muldiv_queue.sv
      - source/muldiv_engine.sv
      - source/muldiv_writeback.sv
      - source/muldiv_top.sv
  - target: test
    files:
      - test/muldiv_tb.sv

// File: files.f
source/muldiv_pkg.sv
source/muldiv_issue.sv
source/muldiv_queue.sv
source/muldiv_engine.sv
source/muldiv_writeback.sv
source/muldiv_top.sv
test/muldiv_tb.sv

// File: source/muldiv_engine.sv
/*
 * Sequential unsigned multiply/divide engine, one bit per clock,
 * with operand sign removal before and sign restore after the iterations
 */

module muldiv_engine (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     flush,
	input  logic                     cmd_valid,
	input  muldiv_pkg::muldiv_cmd_t  cmd,
	output logic                     cmd_ready,
	output logic                     raw_valid,
	output muldiv_pkg::muldiv_raw_t  raw,
	input  logic                     raw_ready
);

	localparam int XLEN = muldiv_pkg::XLEN;

	// Control state
	logic                          busy;
	logic                          preadj_done;
	logic                          postadj_done;
	logic                          postadj_carry;
	logic                          prenegate_b;
	logic                          a_neg_r;
	logic                          b_neg_r;
	logic [muldiv_pkg::W_CTR-1:0]  ctr;

	// Operation payload
	logic [2*XLEN-1:0]             accum;
	logic [XLEN-1:0]               b_r;
	muldiv_pkg::muldiv_op_e        op_r;
	logic [muldiv_pkg::W_TAG-1:0]  tag_r;
	logic                          is_div_r;
	logic                          a_signed_r;
	logic                          b_signed_r;
	logic                          take_high_r;
	logic                          dbz_r;

	// Datapath
	logic [XLEN-1:0]               b_adj;
	logic [2*XLEN-1:0]             accum_iter;
	logic [2*XLEN-1:0]             addend;
	logic [2*XLEN-1:0]             shifted;
	logic [2*XLEN-1:0]             trial;
	logic [XLEN-1:0]               neg_lo;
	logic                          neg_l_carry;
	logic [XLEN-1:0]               hi_fix;
	logic [2*XLEN-1:0]             accum_d;

	// Sequencing
	logic a_neg;
	logic b_neg;
	logic signs_differ;
	logic preadj_phase;
	logic preadj_adjust;
	logic do_postadj;
	logic iter_en;
	logic accum_neg_l;
	logic accum_inv_h;
	logic accum_incr_h;
	logic post_adjust;

	// --------------------------------------------------------------------
	// Sign decode

	// A zero divisor keeps a unnegated, so hi ends up holding the dividend
	assign a_neg = a_signed_r && accum[XLEN-1] && !dbz_r;
	assign b_neg = b_signed_r && b_r[XLEN-1];
	assign signs_differ = a_neg_r ^ b_neg_r;

	// Multiply adds |b|, divide adds -|b| as a trial subtract
	assign b_adj = prenegate_b ? -b_r : b_r;

	assign preadj_phase  = busy && !preadj_done;
	assign preadj_adjust = a_neg || (b_neg ^ is_div_r);
	assign do_postadj    = busy && preadj_done && ctr == '0 && !postadj_done;

	// Low half negation: |a| before, product or quotient sign after
	// Remainder-only ops leave the quotient alone
	assign accum_neg_l = (preadj_phase && a_neg) ||
		(do_postadj && !postadj_carry && signs_differ && !(is_div_r && take_high_r));

	// High half fix only matters when the upper half is returned
	// Remainder is negated in one go, product high half is inverted then incremented
	assign accum_inv_h  = do_postadj && take_high_r && !postadj_carry &&
		(is_div_r ? a_neg_r : signs_differ);
	assign accum_incr_h = do_postadj && take_high_r && (is_div_r ? a_neg_r : postadj_carry);

	assign post_adjust = accum_neg_l || accum_inv_h || accum_incr_h;
	assign iter_en = preadj_phase ? !preadj_adjust : (busy && ctr != '0);

	// --------------------------------------------------------------------
	// Arithmetic

	always_comb begin
		accum_iter = accum;
		addend     = '0;
		shifted    = '0;
		trial      = '0;
		for (int i = 0; i < muldiv_pkg::MULDIV_UNROLL; i++) begin
			// Top bit sign-extends the negative divisor
			addend  = {is_div_r && |b_adj, b_adj, {(XLEN-1){1'b0}}};
			shifted = is_div_r ? accum_iter : accum_iter >> 1;
			trial   = shifted + addend;
			if (is_div_r)
				accum_iter = {(trial[2*XLEN-1] ? shifted[2*XLEN-2:0] : trial[2*XLEN-2:0]),
					!trial[2*XLEN-1]};
			else
				accum_iter = accum_iter[0] ? trial : shifted;
		end
	end

	assign {neg_l_carry, neg_lo} = {1'b0, ~accum[XLEN-1:0]} + {{XLEN{1'b0}}, 1'b1};
	assign hi_fix = (accum[2*XLEN-1:XLEN] ^ {XLEN{accum_inv_h}}) +
		{{(XLEN-1){1'b0}}, accum_incr_h};

	always_comb begin
		accum_d = accum;
		if (iter_en)
			accum_d = accum_iter;
		if (accum_neg_l)
			accum_d[XLEN-1:0] = neg_lo;
		if (accum_inv_h || accum_incr_h)
			accum_d[2*XLEN-1:XLEN] = hi_fix;
	end

	// --------------------------------------------------------------------
	// Handshakes

	assign cmd_ready = !busy;
	assign raw_valid = busy && preadj_done && ctr == '0 && !post_adjust;
	assign raw = '{hi: accum[2*XLEN-1:XLEN], lo: accum[XLEN-1:0], op: op_r, tag: tag_r,
		div_by_zero: dbz_r};

	// Sequencer: load, pre-adjust, iterate, post-adjust, wait for writeback
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy          <= 1'b0;
			ctr           <= '0;
			preadj_done   <= 1'b1;
			postadj_done  <= 1'b1;
			postadj_carry <= 1'b0;
			prenegate_b   <= 1'b0;
			a_neg_r       <= 1'b0;
			b_neg_r       <= 1'b0;
		end else if (flush) begin
			busy          <= 1'b0;
			ctr           <= '0;
			preadj_done   <= 1'b1;
			postadj_done  <= 1'b1;
			postadj_carry <= 1'b0;
		end else if (cmd_valid && cmd_ready) begin
			busy          <= 1'b1;
			ctr           <= muldiv_pkg::CTR_TOP;
			preadj_done   <= 1'b0;
			postadj_done  <= 1'b0;
			postadj_carry <= 1'b0;
			prenegate_b   <= 1'b0;
		end else if (raw_valid && raw_ready) begin
			busy <= 1'b0;
		end else if (preadj_phase) begin
			a_neg_r     <= a_neg;
			b_neg_r     <= b_neg;
			preadj_done <= 1'b1;
			prenegate_b <= b_neg ^ is_div_r;
			// Nothing to adjust, so this cycle is the first iteration
			if (!preadj_adjust)
				ctr <= ctr - muldiv_pkg::CTR_STEP;
		end else if (ctr != '0) begin
			ctr <= ctr - muldiv_pkg::CTR_STEP;
		end else if (post_adjust) begin
			// Low half negation of a product may carry into the high half
			postadj_carry <= accum_neg_l && !is_div_r && take_high_r && neg_l_carry;
			postadj_done  <= !(accum_neg_l && !is_div_r && take_high_r && neg_l_carry);
		end
	end

	// Operand capture and accumulator update
	always_ff @(posedge clk) begin
		if (cmd_valid && cmd_ready) begin
			accum       <= {{XLEN{1'b0}}, cmd.a};
			b_r         <= cmd.b;
			op_r        <= cmd.op;
			tag_r       <= cmd.tag;
			is_div_r    <= cmd.is_div;
			a_signed_r  <= cmd.a_signed;
			b_signed_r  <= cmd.b_signed;
			take_high_r <= cmd.take_high;
			dbz_r       <= cmd.is_div && cmd.b == '0;
		end else if (busy) begin
			accum <= accum_d;
		end
	end

endmodule

// File: source/muldiv_issue.sv
/*
 * Issue stage: decodes a request into an engine command and holds it
 * in a single pipeline register
 */

module muldiv_issue (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     flush,
	input  logic                     req_valid,
	input  muldiv_pkg::muldiv_req_t  req,
	output logic                     req_ready,
	output logic                     cmd_valid,
	output muldiv_pkg::muldiv_cmd_t  cmd,
	input  logic                     cmd_ready
);

	logic                    ready_en;
	muldiv_pkg::muldiv_cmd_t cmd_d;

	// Operation decode, done once here for every later stage
	always_comb begin
		cmd_d.op        = req.op;
		cmd_d.a         = req.a;
		cmd_d.b         = req.b;
		cmd_d.tag       = req.tag;
		cmd_d.is_div    = req.op[2];
		cmd_d.a_signed  = req.op inside {muldiv_pkg::OP_MULH, muldiv_pkg::OP_MULHSU,
			muldiv_pkg::OP_DIV, muldiv_pkg::OP_REM};
		cmd_d.b_signed  = req.op inside {muldiv_pkg::OP_MULH, muldiv_pkg::OP_DIV,
			muldiv_pkg::OP_REM};
		// Upper half holds mulh* products and rem* remainders
		cmd_d.take_high = !(req.op inside {muldiv_pkg::OP_MUL, muldiv_pkg::OP_DIV,
			muldiv_pkg::OP_DIVU});
	end

	// Accept when the register is empty or drains this cycle, never during flush
	assign req_ready = ready_en && !flush && (!cmd_valid || cmd_ready);

	// Ready stays low until the first edge after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready_en  <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			ready_en <= 1'b1;
			if (flush)
				cmd_valid <= 1'b0;
			else if (req_valid && req_ready)
				cmd_valid <= 1'b1;
			else if (cmd_ready)
				cmd_valid <= 1'b0;
		end
	end

	// Command payload
	always_ff @(posedge clk) begin
		if (req_valid && req_ready)
			cmd <= cmd_d;
	end

endmodule

// File: source/muldiv_pkg.sv
/*
 * Shared definitions of the multiply/divide unit: widths, operation codes,
 * and the request, command, raw result and response structs
 */

package muldiv_pkg;

	// --------------------------------------------------------------------
	// Widths and sizes
	localparam int XLEN          = 32;
	localparam int W_CTR         = $clog2(XLEN + 1);
	localparam int MULDIV_UNROLL = 1;
	localparam int QUEUE_DEPTH   = 4;
	localparam int W_TAG         = 4;

	// Iteration counter start value and step
	localparam logic [W_CTR-1:0] CTR_TOP  = W_CTR'(XLEN);
	localparam logic [W_CTR-1:0] CTR_STEP = W_CTR'(MULDIV_UNROLL);

	// Command queue pointer and occupancy widths, depth is a power of two
	localparam int W_QPTR = $clog2(QUEUE_DEPTH);
	localparam int W_QCNT = $clog2(QUEUE_DEPTH + 1);
	localparam logic [W_QCNT-1:0] QCNT_FULL = W_QCNT'(QUEUE_DEPTH);

	// --------------------------------------------------------------------
	// Operations in funct3 order, bit 2 marks a divide
	typedef enum logic [2:0] {
		OP_MUL    = 3'd0,
		OP_MULH   = 3'd1,
		OP_MULHSU = 3'd2,
		OP_MULHU  = 3'd3,
		OP_DIV    = 3'd4,
		OP_DIVU   = 3'd5,
		OP_REM    = 3'd6,
		OP_REMU   = 3'd7
	} muldiv_op_e;

	// Request from the core
	typedef struct packed {
		muldiv_op_e        op;
		logic [XLEN-1:0]   a;
		logic [XLEN-1:0]   b;
		logic [W_TAG-1:0]  tag;
	} muldiv_req_t;

	// Decoded command, sign and half controls already worked out
	typedef struct packed {
		muldiv_op_e        op;
		logic [XLEN-1:0]   a;
		logic [XLEN-1:0]   b;
		logic [W_TAG-1:0]  tag;
		logic              is_div;
		logic              a_signed;
		logic              b_signed;
		logic              take_high;
	} muldiv_cmd_t;

	// Response back to the core
	typedef struct packed {
		logic [XLEN-1:0]   result;
		logic [W_TAG-1:0]  tag;
	} muldiv_resp_t;

	// Full engine result before half selection
	typedef struct packed {
		logic [XLEN-1:0]   hi;
		logic [XLEN-1:0]   lo;
		muldiv_op_e        op;
		logic [W_TAG-1:0]  tag;
		logic              div_by_zero;
	} muldiv_raw_t;

endpackage

// File: source/muldiv_queue.sv
/*
 * Command queue: circular FIFO of decoded commands between issue
 * and the engine, emptied by flush
 */

module muldiv_queue (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     flush,
	input  logic                     in_valid,
	input  muldiv_pkg::muldiv_cmd_t  in_cmd,
	output logic                     in_ready,
	output logic                     out_valid,
	output muldiv_pkg::muldiv_cmd_t  out_cmd,
	input  logic                     out_ready
);

	muldiv_pkg::muldiv_cmd_t          mem [muldiv_pkg::QUEUE_DEPTH];
	logic [muldiv_pkg::W_QPTR-1:0]    wr_ptr;
	logic [muldiv_pkg::W_QPTR-1:0]    rd_ptr;
	logic [muldiv_pkg::W_QCNT-1:0]    count;
	logic                             push;
	logic                             pop;

	// Full and empty straight from the occupancy count
	assign in_ready  = count != muldiv_pkg::QCNT_FULL;
	assign out_valid = count != '0;
	assign out_cmd   = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	// --------------------------------------------------------------------
	// Pointers and count, pointers wrap naturally at the depth
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leaves the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_cmd;
	end

endmodule

// File: source/muldiv_top.sv
/*
 * Multiply/divide unit top level
 * Issue, command queue, engine and writeback in a valid/ready chain
 */

module muldiv_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      flush,
	input  logic                      req_valid,
	input  muldiv_pkg::muldiv_req_t   req,
	output logic                      req_ready,
	output logic                      resp_valid,
	output muldiv_pkg::muldiv_resp_t  resp,
	input  logic                      resp_ready
);

	// Issue to queue
	logic                     iss_valid;
	logic                     iss_ready;
	muldiv_pkg::muldiv_cmd_t  iss_cmd;

	// Queue to engine
	logic                     eng_valid;
	logic                     eng_ready;
	muldiv_pkg::muldiv_cmd_t  eng_cmd;

	// Engine to writeback
	logic                     raw_valid;
	logic                     raw_ready;
	muldiv_pkg::muldiv_raw_t  raw;

	muldiv_issue u_issue (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.cmd_valid (iss_valid),
		.cmd       (iss_cmd),
		.cmd_ready (iss_ready)
	);

	muldiv_queue u_queue (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.in_valid  (iss_valid),
		.in_cmd    (iss_cmd),
		.in_ready  (iss_ready),
		.out_valid (eng_valid),
		.out_cmd   (eng_cmd),
		.out_ready (eng_ready)
	);

	muldiv_engine u_engine (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.cmd_valid (eng_valid),
		.cmd       (eng_cmd),
		.cmd_ready (eng_ready),
		.raw_valid (raw_valid),
		.raw       (raw),
		.raw_ready (raw_ready)
	);

	muldiv_writeback u_writeback (
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.raw_valid  (raw_valid),
		.raw        (raw),
		.raw_ready  (raw_ready),
		.resp_valid (resp_valid),
		.resp       (resp),
		.resp_ready (resp_ready)
	);

endmodule

// File: source/muldiv_writeback.sv
/*
 * Writeback: selects the result half, applies the divide-by-zero rule
 * and holds the response until the core takes it
 */

module muldiv_writeback (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      flush,
	input  logic                      raw_valid,
	input  muldiv_pkg::muldiv_raw_t   raw,
	output logic                      raw_ready,
	output logic                      resp_valid,
	output muldiv_pkg::muldiv_resp_t  resp,
	input  logic                      resp_ready
);

	logic                        take_low;
	logic [muldiv_pkg::XLEN-1:0] result_d;

	// --------------------------------------------------------------------
	// Result selection

	always_comb begin
		// mul, div and divu return the low half
		take_low = raw.op inside {muldiv_pkg::OP_MUL, muldiv_pkg::OP_DIV, muldiv_pkg::OP_DIVU};
		result_d = take_low ? raw.lo : raw.hi;
		// Zero divisor gives an all-ones quotient
		// Remainder already holds the dividend in hi
		if (raw.div_by_zero && take_low)
			result_d = '1;
	end

	// Register is free when empty or being taken this cycle
	assign raw_ready = !resp_valid || resp_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			resp_valid <= 1'b0;
		else if (flush)
			resp_valid <= 1'b0;
		else if (raw_valid && raw_ready)
			resp_valid <= 1'b1;
		else if (resp_ready)
			resp_valid <= 1'b0;
	end

	// Response payload, stable while waiting on the core
	always_ff @(posedge clk) begin
		if (raw_valid && raw_ready) begin
			resp.result <= result_d;
			resp.tag    <= raw.tag;
		end
	end

endmodule

// File: test/muldiv_tb.sv
/*
 * Testbench of the multiply/divide unit: directed table, LFSR random
 * operands with a 64-bit reference model, back-pressure and flush runs
 */

module muldiv_tb;

	localparam int XLEN         = muldiv_pkg::XLEN;
	localparam int N_DIR        = 28;
	localparam int N_RAND       = 24;
	localparam int N_BP         = 32;
	localparam int N_FLUSH      = 3;
	localparam int N_REQ        = N_DIR + N_RAND + N_BP + N_FLUSH + 1;
	localparam int CYCLE_LIMIT  = N_REQ * 60 + 500;
	// Longer than the worst-case latency of about 39 cycles
	localparam int QUIET_CYCLES = 60;

	// One stimulus row with its expected result
	typedef struct packed {
		muldiv_pkg::muldiv_op_e  op;
		logic [XLEN-1:0]         a;
		logic [XLEN-1:0]         b;
		logic [XLEN-1:0]         exp;
	} row_t;

	// Outstanding request, in issue order
	typedef struct packed {
		logic [muldiv_pkg::W_TAG-1:0]  tag;
		row_t                          row;
	} pending_t;

	// Directed rows, expected values worked out by hand from the RISC-V rules
	localparam row_t DIR_ROWS [N_DIR] = '{
		'{muldiv_pkg::OP_MUL,    32'h0000_0003, 32'h0000_0007, 32'h0000_0015},
		'{muldiv_pkg::OP_MUL,    32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001},
		'{muldiv_pkg::OP_MUL,    32'hffff_fffe, 32'h0000_0003, 32'hffff_fffa},
		'{muldiv_pkg::OP_MUL,    32'h0000_0000, 32'h1234_5678, 32'h0000_0000},
		'{muldiv_pkg::OP_MULH,   32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000},
		'{muldiv_pkg::OP_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000},
		'{muldiv_pkg::OP_MULH,   32'h8000_0000, 32'h0000_0001, 32'hffff_ffff},
		'{muldiv_pkg::OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff},
		'{muldiv_pkg::OP_MULHSU, 32'h8000_0000, 32'h8000_0000, 32'hc000_0000},
		'{muldiv_pkg::OP_MULHSU, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0000},
		'{muldiv_pkg::OP_MULHU,  32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe},
		'{muldiv_pkg::OP_MULHU,  32'h0000_0000, 32'hffff_ffff, 32'h0000_0000},
		'{muldiv_pkg::OP_DIV,    32'h0000_0014, 32'h0000_0003, 32'h0000_0006},
		'{muldiv_pkg::OP_DIV,    32'hffff_ffec, 32'h0000_0003, 32'hffff_fffa},
		'{muldiv_pkg::OP_DIV,    32'h8000_0000, 32'hffff_ffff, 32'h8000_0000},
		'{muldiv_pkg::OP_DIV,    32'h1234_5678, 32'h0000_0000, 32'hffff_ffff},
		'{muldiv_pkg::OP_DIVU,   32'hffff_ffff, 32'h0000_0002, 32'h7fff_ffff},
		'{muldiv_pkg::OP_DIVU,   32'h1234_5678, 32'h0000_0000, 32'hffff_ffff},
		'{muldiv_pkg::OP_DIVU,   32'h8000_0000, 32'hffff_ffff, 32'h0000_0000},
		'{muldiv_pkg::OP_REM,    32'hffff_ffec, 32'h0000_0003, 32'hffff_fffe},
		'{muldiv_pkg::OP_REM,    32'h0000_0014, 32'hffff_fffd, 32'h0000_0002},
		'{muldiv_pkg::OP_REM,    32'h8000_0000, 32'hffff_ffff, 32'h0000_0000},
		'{muldiv_pkg::OP_REM,    32'h8765_4321, 32'h0000_0000, 32'h8765_4321},
		'{muldiv_pkg::OP_REMU,   32'hffff_ffff, 32'h0000_000a, 32'h0000_0005},
		'{muldiv_pkg::OP_REMU,   32'h8765_4321, 32'h0000_0000, 32'h8765_4321},
		'{muldiv_pkg::OP_DIV,    32'h0000_0000, 32'h0000_0005, 32'h0000_0000},
		'{muldiv_pkg::OP_REM,    32'h0000_0000, 32'hffff_ffff, 32'h0000_0000},
		'{muldiv_pkg::OP_REMU,   32'h8000_0000, 32'hffff_ffff, 32'h8000_0000}
	};

	logic                          clk;
	logic                          rst_n;
	logic                          flush;
	logic                          req_valid;
	muldiv_pkg::muldiv_req_t       req;
	logic                          req_ready;
	logic                          resp_valid;
	muldiv_pkg::muldiv_resp_t      resp;
	logic                          resp_ready;

	pending_t                      pending [$];
	logic [muldiv_pkg::W_TAG-1:0]  next_tag;
	logic [31:0]                   lfsr_state;
	logic                          bp_mode;
	logic                          hold_check;
	muldiv_pkg::muldiv_resp_t      held_resp;
	int                            pass_count;
	int                            fail_count;
	int                            err_count;
	int                            test_count;
	int                            cycles = 0;
	row_t                          row;

	muldiv_top UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.req_valid  (req_valid),
		.req        (req),
		.req_ready  (req_ready),
		.resp_valid (resp_valid),
		.resp       (resp),
		.resp_ready (resp_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// Random source and reference model

	// Galois LFSR, taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	// 64-bit arithmetic with the RISC-V divide-by-zero and overflow rules
	function automatic logic [XLEN-1:0] ref_result(input muldiv_pkg::muldiv_op_e op,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic signed [2*XLEN-1:0] sa;
		logic signed [2*XLEN-1:0] sb;
		logic signed [2*XLEN-1:0] ua;
		logic signed [2*XLEN-1:0] ub;
		logic signed [2*XLEN-1:0] r;
		sa = {{XLEN{a[XLEN-1]}}, a};
		sb = {{XLEN{b[XLEN-1]}}, b};
		ua = {{XLEN{1'b0}}, a};
		ub = {{XLEN{1'b0}}, b};
		case (op)
			muldiv_pkg::OP_MUL,
			muldiv_pkg::OP_MULH:   r = sa * sb;
			muldiv_pkg::OP_MULHSU: r = sa * ub;
			muldiv_pkg::OP_MULHU:  r = ua * ub;
			muldiv_pkg::OP_DIV:    r = (b == '0) ? -1 : sa / sb;
			muldiv_pkg::OP_DIVU:   r = (b == '0) ? -1 : ua / ub;
			// Remainder truncates, so it follows the dividend's sign
			muldiv_pkg::OP_REM:    r = (b == '0) ? sa : sa % sb;
			default:               r = (b == '0) ? ua : ua % ub;
		endcase
		if (op inside {muldiv_pkg::OP_MULH, muldiv_pkg::OP_MULHSU, muldiv_pkg::OP_MULHU})
			return r[2*XLEN-1:XLEN];
		return r[XLEN-1:0];
	endfunction

	// Random op and operands, divisor shifted down to vary its size
	task automatic gen_row(output row_t r);
		logic [31:0] bits;
		bits  = rand_bits(3);
		r.op  = muldiv_pkg::muldiv_op_e'(bits[2:0]);
		r.a   = rand_bits(XLEN);
		r.b   = rand_bits(XLEN) >> rand_bits(5);
		r.exp = ref_result(r.op, r.a, r.b);
	endtask

	// ----------------------------------------------------------------------
	// Driving, all on the falling edge from the main process

	// resp_ready comes from LFSR bits while back-pressure is on
	task automatic next_cycle();
		logic [31:0] bit_v;
		@(negedge clk);
		bit_v = bp_mode ? rand_bits(1) : 32'h1;
		resp_ready = bit_v[0];
	endtask

	// Holds the request until the DUT takes it
	task automatic send_req(input row_t r, input logic track);
		pending_t rec;
		logic     accepted;
		rec.tag   = next_tag;
		rec.row   = r;
		req       = '{op: r.op, a: r.a, b: r.b, tag: next_tag};
		req_valid = 1'b1;
		accepted  = 1'b0;
		while (!accepted) begin
			@(posedge clk);
			accepted = req_ready;
			if (accepted && track)
				pending.push_back(rec);
			next_cycle();
		end
		req_valid = 1'b0;
		next_tag  = next_tag + 1'b1;
	endtask

	task automatic wait_drain();
		while (pending.size() != 0)
			next_cycle();
	endtask

	// ----------------------------------------------------------------------
	// Response checking at the rising edge, before the DUT registers update

	task automatic check_response();
		pending_t               e;
		muldiv_pkg::muldiv_op_e op_v;
		logic                   ok;
		if (pending.size() == 0) begin
			$display("ERROR at %0t: response with tag %h arrived with no request outstanding",
				$time, resp.tag);
			err_count++;
			return;
		end
		e    = pending.pop_front();
		op_v = e.row.op;
		ok   = 1'b1;
		test_count++;
		if (resp.tag !== e.tag) begin
			$display("MISMATCH at %0t: %s tag got %h expected %h", $time, op_v.name(),
				resp.tag, e.tag);
			ok = 1'b0;
		end
		if (resp.result !== e.row.exp) begin
			$display("MISMATCH at %0t: %s a=%h b=%h got %h expected %h", $time, op_v.name(),
				e.row.a, e.row.b, resp.result, e.row.exp);
			ok = 1'b0;
		end
		if (ok)
			pass_count++;
		else
			fail_count++;
		$display("Test %0d %s a=%h b=%h tag=%h result=%h %s", test_count, op_v.name(),
			e.row.a, e.row.b, resp.tag, resp.result, ok ? "ok" : "FAILED");
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			// Stalled response must not move
			if (hold_check && !(resp_valid && resp === held_resp)) begin
				$display("ERROR at %0t: response changed or dropped while stalled", $time);
				err_count++;
			end
			if (resp_valid && resp_ready)
				check_response();
			hold_check = resp_valid && !resp_ready && !flush;
			held_resp  = resp;
		end
	end

	// Run limit from the request count
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles: responses stopped arriving, %0d outstanding",
				cycles, pending.size());
			$display("Verification failed");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// Test sequence

	initial begin
		lfsr_state = 32'h96d0_f631;
		rst_n      = 1'b0;
		flush      = 1'b0;
		req_valid  = 1'b0;
		req        = '0;
		resp_ready = 1'b0;
		bp_mode    = 1'b0;
		next_tag   = '0;
		hold_check = 1'b0;
		held_resp  = '0;
		pass_count = 0;
		fail_count = 0;
		err_count  = 0;
		test_count = 0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		next_cycle();

		// Directed table, back-to-back
		for (int i = 0; i < N_DIR; i++)
			send_req(DIR_ROWS[i], 1'b1);
		wait_drain();

		// Random operands, core always ready
		for (int i = 0; i < N_RAND; i++) begin
			gen_row(row);
			send_req(row, 1'b1);
		end
		wait_drain();

		// Random operands under back-pressure, fills the queue
		bp_mode = 1'b1;
		for (int i = 0; i < N_BP; i++) begin
			gen_row(row);
			send_req(row, 1'b1);
		end
		wait_drain();
		bp_mode = 1'b0;
		next_cycle();

		// Untracked requests, killed mid-calculation
		for (int i = 0; i < N_FLUSH; i++) begin
			gen_row(row);
			send_req(row, 1'b0);
		end
		repeat (4) next_cycle();
		flush = 1'b1;
		next_cycle();
		flush = 1'b0;
		// Any response in this window has no outstanding request
		repeat (QUIET_CYCLES) next_cycle();
		gen_row(row);
		send_req(row, 1'b1);
		wait_drain();

		$display("Tests passed %0d, failed %0d, other errors %0d", pass_count, fail_count,
			err_count);
		if (fail_count == 0 && err_count == 0 && test_count == N_REQ - N_FLUSH)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
